// File: issue_read_operands.f
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/operand_hazard_check.sv
hdl/operand_select.sv
hdl/fu_dispatch.sv
hdl/issue_read_operands.sv
test/tb_issue_read_operands.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_read_operands \
    -f issue_read_operands.f \
    -o tb_issue_read_operands \
    && ./obj_dir/tb_issue_read_operands > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1

// File: test/tb_issue_read_operands.sv
/*
 * testbench for the operand-read issue stage
 * clock, reset, LFSR, register model and reference function,
 * output comparison, directed sequences and a random phase
 */
`timescale 1ns/1ns

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int          ACK_TIMEOUT     = 40;

    // what the DUT should show for one presented cycle
    typedef struct packed {
        logic       ack;
        logic [4:0] strobe;     // {csr, mult, lsu, branch, alu}
        fu_data_t   data;
    } expect_t;

    logic                              clk_i;
    logic                              rst_uarch_ni;
    logic                              flush_i;
    issue_entry_t                      issue_instr_i;
    logic                              issue_instr_valid_i;
    logic                              issue_ack_o;
    xlen_t                             rs1_value_i;
    logic                              rs1_valid_i;
    xlen_t                             rs2_value_i;
    logic                              rs2_valid_i;
    clobber_table_t                    rd_clobber_i;
    reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i;
    xlen_t     [NR_COMMIT_PORTS-1:0]   wdata_i;
    logic      [NR_COMMIT_PORTS-1:0]   we_i;
    logic                              flu_ready_i;
    logic                              lsu_ready_i;
    fu_data_t                          fu_data_o;
    logic                              alu_valid_o;
    logic                              branch_valid_o;
    logic                              lsu_valid_o;
    logic                              mult_valid_o;
    logic                              csr_valid_o;

    xlen_t        model_regs [NUM_REGS];
    logic         model_mult;   // mult strobe expected in the current cycle
    expect_t      exp_q;
    logic         check_en;
    logic         ack_seen;
    logic [31:0]  lfsr_q;
    int           err_count;
    string        test_name;
    issue_entry_t e;
    fu_data_t     rst_data;

    issue_read_operands #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) issue_read_operands_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------
    // helpers
    // --------------------
    task automatic fail_run(input string why);
        err_count++;
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string what, input logic [127:0] exp_v,
                           input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("MISMATCH %s %s: expected %0h actual %0h",
                               test_name, what, exp_v, act_v));
        end
    endtask

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic fu_t rand_fu();
        logic [2:0] f;
        f = 3'(rand_bits(3));
        // unused code folds onto ALU
        if (f == 3'd7) begin
            f = 3'd3;
        end
        return fu_t'(f);
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic expect_t predict();
        expect_t    x;
        fu_t        c1;
        fu_t        c2;
        logic       fwd1;
        logic       fwd2;
        logic       hold;
        logic       ready;
        logic       rd_ok;
        x  = '0;
        // zimm carries data in the rs1 field, so no clobber lookup
        c1 = issue_instr_i.use_zimm ? NONE : rd_clobber_i[issue_instr_i.rs1];
        c2 = rd_clobber_i[issue_instr_i.rs2];
        fwd1 = (c1 != NONE) && rs1_valid_i &&
               ((c1 != CSR) || (issue_instr_i.op == SFENCE_VMA));
        fwd2 = (c2 != NONE) && rs2_valid_i &&
               ((c2 != CSR) || (issue_instr_i.op == SFENCE_VMA));
        hold = ((c1 != NONE) && !fwd1) || ((c2 != NONE) && !fwd2);
        case (issue_instr_i.fu)
            LOAD, STORE: ready = lsu_ready_i;
            NONE:        ready = 1'b1;
            default:     ready = flu_ready_i;
        endcase
        rd_ok = (rd_clobber_i[issue_instr_i.rd] == NONE);
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == issue_instr_i.rd)) begin
                rd_ok = 1'b1;
            end
        end
        x.ack = issue_instr_valid_i &&
                ((!hold && ready && rd_ok) || issue_instr_i.ex_valid ||
                 (issue_instr_i.fu == NONE)) &&
                !(model_mult && (issue_instr_i.fu != MULT));
        if (x.ack && !issue_instr_i.ex_valid && !flush_i) begin
            case (issue_instr_i.fu)
                ALU:         x.strobe = 5'b00001;
                CTRL_FLOW:   x.strobe = 5'b00010;
                LOAD, STORE: x.strobe = 5'b00100;
                MULT:        x.strobe = 5'b01000;
                CSR:         x.strobe = 5'b10000;
                default:     x.strobe = 5'b00000;
            endcase
        end
        x.data.fu        = issue_instr_i.fu;
        x.data.op        = issue_instr_i.op;
        x.data.trans_id  = issue_instr_i.trans_id;
        x.data.imm       = issue_instr_i.result;
        x.data.operand_a = fwd1 ? rs1_value_i : model_regs[issue_instr_i.rs1];
        if (issue_instr_i.use_pc) begin
            x.data.operand_a = issue_instr_i.pc;
        end
        if (issue_instr_i.use_zimm) begin
            x.data.operand_a = {27'b0, issue_instr_i.rs1};
        end
        x.data.operand_b = fwd2 ? rs2_value_i : model_regs[issue_instr_i.rs2];
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
            (issue_instr_i.fu != CTRL_FLOW)) begin
            x.data.operand_b = issue_instr_i.result;
        end
        return x;
    endfunction

    // output comparison, ack between edges and registered outputs after the edge
    initial begin : compare_outputs
        forever begin
            @(negedge clk_i);
            #1;
            if (check_en) begin
                compare("issue ack", 128'(exp_q.ack), 128'(issue_ack_o));
            end
            @(posedge clk_i);
            #1;
            if (check_en) begin
                compare("unit strobes", 128'(exp_q.strobe),
                        128'({csr_valid_o, mult_valid_o, lsu_valid_o,
                              branch_valid_o, alu_valid_o}));
                compare("fu data", 128'(exp_q.data), 128'(fu_data_o));
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    // called at a falling edge with the inputs set, returns at the next one
    task automatic step();
        exp_q = predict();
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] != '0)) begin
                model_regs[waddr_i[p]] = wdata_i[p];
            end
        end
        model_mult = exp_q.strobe[3];
        check_en   = 1'b1;
        #1;
        ack_seen = issue_ack_o;
        @(negedge clk_i);
        we_i    = '0;
        flush_i = 1'b0;
    endtask

    task automatic idle();
        issue_instr_i       = '0;
        issue_instr_valid_i = 1'b0;
        rs1_value_i         = '0;
        rs1_valid_i         = 1'b0;
        rs2_value_i         = '0;
        rs2_valid_i         = 1'b0;
        waddr_i             = '0;
        wdata_i             = '0;
        we_i                = '0;
        flu_ready_i         = 1'b1;
        lsu_ready_i         = 1'b1;
        flush_i             = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            rd_clobber_i[r] = NONE;
        end
    endtask

    task automatic commit(input int p, input reg_addr_t a, input xlen_t d);
        we_i[p]    = 1'b1;
        waddr_i[p] = a;
        wdata_i[p] = d;
    endtask

    function automatic issue_entry_t new_entry(input fu_t fu, input fu_op_t op,
            input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd);
        issue_entry_t n;
        n          = '0;
        n.pc       = 32'h8000_0400;
        n.result   = 32'h0000_0abc;
        n.trans_id = 3'd5;
        n.fu       = fu;
        n.op       = op;
        n.rs1      = rs1;
        n.rs2      = rs2;
        n.rd       = rd;
        return n;
    endfunction

    function automatic issue_entry_t random_entry();
        issue_entry_t n;
        n          = '0;
        n.pc       = rand_bits(32);
        n.trans_id = 3'(rand_bits(3));
        n.fu       = rand_fu();
        n.op       = fu_op_t'(4'(rand_bits(4) % 13));
        n.rs1      = 5'(rand_bits(5));
        n.rs2      = 5'(rand_bits(5));
        n.rd       = 5'(rand_bits(5));
        n.result   = rand_bits(32);
        n.use_imm  = rand_bit();
        n.use_pc   = (rand_bits(2) == 0);
        n.use_zimm = (rand_bits(2) == 0);
        n.ex_valid = (rand_bits(4) == 0);
        return n;
    endfunction

    // new scoreboard and commit state per retry, quiet after eight tries
    task automatic shake_env(input int tries);
        for (int r = 1; r < NUM_REGS; r++) begin
            rd_clobber_i[r] = ((tries < 8) && (rand_bits(3) == 0)) ? rand_fu() : NONE;
        end
        rs1_value_i = rand_bits(32);
        rs1_valid_i = rand_bit();
        rs2_value_i = rand_bits(32);
        rs2_valid_i = rand_bit();
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            we_i[p]    = rand_bit();
            waddr_i[p] = 5'(rand_bits(5));
            wdata_i[p] = rand_bits(32);
        end
        flu_ready_i = (tries >= 8) || (rand_bits(2) != 0);
        lsu_ready_i = (tries >= 8) || (rand_bits(2) != 0);
        flush_i     = (rand_bits(4) == 0);
    endtask

    // one cycle with the entry, ack expected as given, then valid drops
    task automatic present(input issue_entry_t n, input logic exp_ack);
        issue_instr_i       = n;
        issue_instr_valid_i = 1'b1;
        step();
        compare("held ack", 128'(exp_ack), 128'(ack_seen));
        issue_instr_valid_i = 1'b0;
    endtask

    // hold the entry until the DUT acks it
    task automatic send(input issue_entry_t n, input logic shake);
        int tries;
        tries               = 0;
        issue_instr_i       = n;
        issue_instr_valid_i = 1'b1;
        if (shake) begin
            shake_env(tries);
        end
        step();
        while (!ack_seen) begin
            tries++;
            if (tries > ACK_TIMEOUT) begin
                fail_run($sformatf("timeout: %s entry was never acked", test_name));
            end else begin
                if (shake) begin
                    shake_env(tries);
                end
                step();
            end
        end
        issue_instr_valid_i = 1'b0;
    endtask

    initial begin : stimulus
        lfsr_q     = 32'h79eb_ff60;
        check_en   = 1'b0;
        ack_seen   = 1'b0;
        err_count  = 0;
        model_mult = 1'b0;
        test_name  = "reset";
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        rst_uarch_ni = 1'b0;
        idle();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_uarch_ni = 1'b1;
        rst_data     = '0;
        rst_data.fu  = NONE;
        rst_data.op  = ADD;
        compare("fu data", 128'(rst_data), 128'(fu_data_o));
        compare("strobes", 128'd0, 128'({csr_valid_o, mult_valid_o, lsu_valid_o,
                                          branch_valid_o, alu_valid_o}));

        // commits, dual write to x7 and a dropped write to x0
        test_name = "commit_read";
        commit(0, 5'd3, 32'h1111_0003);
        commit(1, 5'd4, 32'h2222_0004);
        step();
        commit(0, 5'd7, 32'haaaa_0007);
        commit(1, 5'd7, 32'hbbbb_0007);
        step();
        commit(0, 5'd0, 32'hdead_beef);
        step();
        send(new_entry(ALU, ADD, 5'd3, 5'd4, 5'd8), 1'b0);
        compare("alu strobe", 128'd1, 128'(alu_valid_o));
        send(new_entry(ALU, SUB, 5'd0, 5'd7, 5'd9), 1'b0);
        compare("x0 operand", 128'd0, 128'(fu_data_o.operand_a));
        compare("x7 operand", 128'(32'hbbbb_0007), 128'(fu_data_o.operand_b));

        // clobbered sources
        test_name       = "clobber";
        rd_clobber_i[3] = ALU;
        rs1_value_i     = 32'hf0f0_1234;
        e               = new_entry(ALU, ADD, 5'd3, 5'd4, 5'd10);
        present(e, 1'b0);
        rs1_valid_i = 1'b1;
        send(e, 1'b0);
        compare("forwarded rs1", 128'(32'hf0f0_1234), 128'(fu_data_o.operand_a));
        rd_clobber_i[3] = CSR;
        present(e, 1'b0);
        send(new_entry(CSR, SFENCE_VMA, 5'd3, 5'd4, 5'd0), 1'b0);
        idle();

        // operand substitution
        test_name = "substitute";
        e         = new_entry(ALU, ADD, 5'd3, 5'd4, 5'd11);
        e.use_pc  = 1'b1;
        e.use_imm = 1'b1;
        send(e, 1'b0);
        compare("pc operand", 128'(32'h8000_0400), 128'(fu_data_o.operand_a));
        compare("imm operand", 128'(32'h0000_0abc), 128'(fu_data_o.operand_b));
        e          = new_entry(CSR, CSRRW, 5'd21, 5'd4, 5'd11);
        e.use_zimm = 1'b1;
        send(e, 1'b0);
        compare("zimm operand", 128'd21, 128'(fu_data_o.operand_a));
        e         = new_entry(STORE, SW, 5'd3, 5'd4, 5'd0);
        e.use_imm = 1'b1;
        send(e, 1'b0);
        compare("store operand b", 128'(32'h2222_0004), 128'(fu_data_o.operand_b));
        e.fu = CTRL_FLOW;
        e.op = BEQ;
        send(e, 1'b0);
        compare("branch operand b", 128'(32'h2222_0004), 128'(fu_data_o.operand_b));

        // write-after-write and pass-through entries
        test_name        = "waw_bypass";
        rd_clobber_i[12] = LOAD;
        e                = new_entry(ALU, OR, 5'd3, 5'd4, 5'd12);
        present(e, 1'b0);
        commit(1, 5'd12, 32'h0c0c_0c0c);
        send(e, 1'b0);
        e.ex_valid = 1'b1;
        send(e, 1'b0);
        compare("exception strobe", 128'd0, 128'(alu_valid_o));
        rd_clobber_i[3] = CSR;
        send(new_entry(NONE, ADD, 5'd3, 5'd4, 5'd12), 1'b0);
        idle();

        // back-pressure, multiply lock and flush
        test_name   = "backpressure";
        flu_ready_i = 1'b0;
        e           = new_entry(ALU, XOR, 5'd3, 5'd4, 5'd13);
        present(e, 1'b0);
        flu_ready_i = 1'b1;
        send(e, 1'b0);
        lsu_ready_i = 1'b0;
        e           = new_entry(LOAD, LW, 5'd3, 5'd0, 5'd14);
        present(e, 1'b0);
        lsu_ready_i = 1'b1;
        send(e, 1'b0);
        test_name = "mult_lock";
        send(new_entry(MULT, MUL, 5'd3, 5'd4, 5'd15), 1'b0);
        e = new_entry(ALU, AND, 5'd3, 5'd4, 5'd16);
        present(e, 1'b0);
        send(e, 1'b0);
        test_name = "flush";
        flush_i   = 1'b1;
        send(new_entry(ALU, SLL, 5'd3, 5'd4, 5'd17), 1'b0);
        compare("flushed strobe", 128'd0, 128'(alu_valid_o));

        // random mix
        test_name = "random";
        for (int n = 0; n < 300; n++) begin
            send(random_entry(), 1'b1);
        end
        idle();
        repeat (3) step();

        if (err_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("errors were counted during the run");
        end
    end

endmodule

// File: hdl/issue_read_operands.sv
/*
 * operand-read issue stage, top level
 * register file, hazard check, operand select and unit dispatch
 */
`timescale 1ns/1ns

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                         clk_i,
    input  logic                                         rst_uarch_ni,
    input  logic                                         flush_i,
    // scoreboard
    input  issue_pkg::issue_entry_t                      issue_instr_i,
    input  logic                                         issue_instr_valid_i,
    output logic                                         issue_ack_o,
    input  issue_pkg::xlen_t                             rs1_value_i,
    input  logic                                         rs1_valid_i,
    input  issue_pkg::xlen_t                             rs2_value_i,
    input  logic                                         rs2_valid_i,
    input  issue_pkg::clobber_table_t                    rd_clobber_i,
    // commit ports
    input  issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
    input  issue_pkg::xlen_t     [NR_COMMIT_PORTS-1:0]   wdata_i,
    input  logic                 [NR_COMMIT_PORTS-1:0]   we_i,
    // execute units
    input  logic                                         flu_ready_i,
    input  logic                                         lsu_ready_i,
    output issue_pkg::fu_data_t                          fu_data_o,
    output logic                                         alu_valid_o,
    output logic                                         branch_valid_o,
    output logic                                         lsu_valid_o,
    output logic                                         mult_valid_o,
    output logic                                         csr_valid_o
);
    import issue_pkg::*;

    xlen_t rdata_a;
    xlen_t rdata_b;
    logic  forward_rs1;
    logic  forward_rs2;
    logic  issue_ack;
    logic  issue_fire;
    logic  mult_issued;

    // entry leaves the scoreboard on this edge
    assign issue_fire   = issue_instr_valid_i & issue_ack;
    assign issue_ack_o  = issue_ack;
    assign mult_valid_o = mult_issued;

    int_regfile #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) int_regfile_inst (
        .clk_i        (clk_i),
        .rst_uarch_ni (rst_uarch_ni),
        .raddr_a_i    (issue_instr_i.rs1),
        .raddr_b_i    (issue_instr_i.rs2),
        .rdata_a_o    (rdata_a),
        .rdata_b_o    (rdata_b),
        .waddr_i      (waddr_i),
        .wdata_i      (wdata_i),
        .we_i         (we_i)
    );

    operand_hazard_check #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) operand_hazard_check_inst (
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .rs1_valid_i         (rs1_valid_i),
        .rs2_valid_i         (rs2_valid_i),
        .waddr_i             (waddr_i),
        .we_i                (we_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .mult_issued_i       (mult_issued),
        .forward_rs1_o       (forward_rs1),
        .forward_rs2_o       (forward_rs2),
        .issue_ack_o         (issue_ack)
    );

    operand_select operand_select_inst (
        .clk_i         (clk_i),
        .rst_uarch_ni  (rst_uarch_ni),
        .issue_instr_i (issue_instr_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .rs1_value_i   (rs1_value_i),
        .rs2_value_i   (rs2_value_i),
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .fu_data_o     (fu_data_o)
    );

    // registered mult strobe feeds back into the ack as the bus lock
    fu_dispatch fu_dispatch_inst (
        .clk_i          (clk_i),
        .rst_uarch_ni   (rst_uarch_ni),
        .fu_i           (issue_instr_i.fu),
        .ex_valid_i     (issue_instr_i.ex_valid),
        .issue_fire_i   (issue_fire),
        .flush_i        (flush_i),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_issued),
        .csr_valid_o    (csr_valid_o)
    );

endmodule

// File: hdl/fu_dispatch.sv
/*
 * functional unit valid strobes
 * one registered strobe per unit after an accepted entry,
 * cleared by flush
 */
`timescale 1ns/1ns

module fu_dispatch (
    input  logic           clk_i,
    input  logic           rst_uarch_ni,
    input  issue_pkg::fu_t fu_i,
    input  logic           ex_valid_i,
    input  logic           issue_fire_i,
    input  logic           flush_i,
    output logic           alu_valid_o,
    output logic           branch_valid_o,
    output logic           lsu_valid_o,
    output logic           mult_valid_o,
    output logic           csr_valid_o
);
    import issue_pkg::*;

    // {csr, mult, lsu, branch, alu}
    logic [4:0] strobe_d;
    logic [4:0] strobe_q;

    // --------------------
    // unit decode
    // --------------------
    always_comb begin
        strobe_d = '0;
        // entries with an exception never reach a unit
        if (issue_fire_i && !ex_valid_i) begin
            case (fu_i)
                ALU:         strobe_d[0] = 1'b1;
                CTRL_FLOW:   strobe_d[1] = 1'b1;
                LOAD, STORE: strobe_d[2] = 1'b1;
                MULT:        strobe_d[3] = 1'b1;
                CSR:         strobe_d[4] = 1'b1;
                default:     strobe_d    = '0;
            endcase
        end
        // flush wins, the unit would start on stale operands
        if (flush_i) begin
            strobe_d = '0;
        end
    end

    // strobes last one cycle since strobe_d defaults to zero
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            strobe_q <= '0;
        end else begin
            strobe_q <= strobe_d;
        end
    end

    assign alu_valid_o    = strobe_q[0];
    assign branch_valid_o = strobe_q[1];
    assign lsu_valid_o    = strobe_q[2];
    assign mult_valid_o   = strobe_q[3];
    assign csr_valid_o    = strobe_q[4];

    // single issue, never two units started together
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
        $onehot0(strobe_q))
        else $error("more than one unit strobe active");

endmodule

// File: hdl/operand_select.sv
/*
 * operand multiplexer and ID/EX stage register
 * picks regfile, forwarded, PC, zimm or immediate operands
 * and registers them with the entry control fields
 */
`timescale 1ns/1ns

module operand_select (
    input  logic                    clk_i,
    input  logic                    rst_uarch_ni,
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  issue_pkg::xlen_t        rdata_a_i,
    input  issue_pkg::xlen_t        rdata_b_i,
    input  issue_pkg::xlen_t        rs1_value_i,
    input  issue_pkg::xlen_t        rs2_value_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    output issue_pkg::fu_data_t     fu_data_o
);
    import issue_pkg::*;

    fu_data_t fu_data_d;

    // --------------------
    // operand mux
    // --------------------
    // later assignments have the higher priority
    always_comb begin
        fu_data_d.fu       = issue_instr_i.fu;
        fu_data_d.op       = issue_instr_i.op;
        fu_data_d.trans_id = issue_instr_i.trans_id;
        fu_data_d.imm      = issue_instr_i.result;

        // operand a
        fu_data_d.operand_a = rdata_a_i;
        if (forward_rs1_i) begin
            fu_data_d.operand_a = rs1_value_i;
        end
        if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = xlen_t'(issue_instr_i.pc);
        end
        // zimm, rs1 field zero-extended
        if (issue_instr_i.use_zimm) begin
            fu_data_d.operand_a = xlen_t'(issue_instr_i.rs1);
        end

        // operand b
        fu_data_d.operand_b = rdata_b_i;
        if (forward_rs2_i) begin
            fu_data_d.operand_b = rs2_value_i;
        end
        // stores keep rs2 as data, branches compare rs2,
        // both see the immediate through imm instead
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
            (issue_instr_i.fu != CTRL_FLOW)) begin
            fu_data_d.operand_b = issue_instr_i.result;
        end
    end

    // --------------------
    // stage register
    // --------------------
    // loads every cycle, the strobes tell the units when it counts
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
        end else begin
            fu_data_o <= fu_data_d;
        end
    end

endmodule

// File: hdl/operand_hazard_check.sv
/*
 * hazard checks for the issue stage
 * source clobber lookup with forward or stall, functional unit
 * busy, write-after-write on rd and the multiply bus lock,
 * combined into the issue ack
 */
`timescale 1ns/1ns

module operand_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_entry_t                      issue_instr_i,
    input  logic                                         issue_instr_valid_i,
    input  issue_pkg::clobber_table_t                    rd_clobber_i,
    input  logic                                         rs1_valid_i,
    input  logic                                         rs2_valid_i,
    input  issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
    input  logic                 [NR_COMMIT_PORTS-1:0]   we_i,
    input  logic                                         flu_ready_i,
    input  logic                                         lsu_ready_i,
    input  logic                                         mult_issued_i,
    output logic                                         forward_rs1_o,
    output logic                                         forward_rs2_o,
    output logic                                         issue_ack_o
);
    import issue_pkg::*;

    // {stall, forward} per source
    logic [1:0] rs1_chk;
    logic [1:0] rs2_chk;
    logic       stall;
    logic       fu_busy;
    logic       rd_free;
    logic       rd_committing;

    // one source operand against the clobber table
    // CSR results cannot be forwarded, they come via the regfile,
    // except for SFENCE_VMA which takes the scoreboard value anyway
    function automatic logic [1:0] src_check(
        input fu_t    clobber,
        input logic   value_valid,
        input fu_op_t op
    );
        logic [1:0] res;
        res = 2'b00;
        if (clobber != NONE) begin
            if (value_valid && ((clobber != CSR) || (op == SFENCE_VMA))) begin
                res = 2'b01;
            end else begin
                res = 2'b10;
            end
        end
        return res;
    endfunction

    // --------------------
    // source operands
    // --------------------
    // zimm reuses the rs1 field as data, nothing to wait on
    assign rs1_chk = issue_instr_i.use_zimm ? 2'b00 :
                     src_check(rd_clobber_i[issue_instr_i.rs1], rs1_valid_i, issue_instr_i.op);
    assign rs2_chk = src_check(rd_clobber_i[issue_instr_i.rs2], rs2_valid_i, issue_instr_i.op);

    assign forward_rs1_o = rs1_chk[0];
    assign forward_rs2_o = rs2_chk[0];
    assign stall         = rs1_chk[1] | rs2_chk[1];

    // --------------------
    // unit busy
    // --------------------
    // fixed latency units share one ready
    always_comb begin
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // WAW on rd
    // --------------------
    assign rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);

    // a pending write that commits this very cycle releases rd
    always_comb begin
        rd_committing = 1'b0;
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // --------------------
    // issue ack
    // --------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries only pass through
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply owns the fixed latency result bus for one more cycle
        if (mult_issued_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // upstream only samples the ack together with valid
    always_comb begin : ack_check
        assert (issue_instr_valid_i || !issue_ack_o)
            else $error("issue ack raised without a valid entry");
    end

endmodule

// File: hdl/int_regfile.sv
/*
 * integer register file
 * two combinational read ports, NR_COMMIT_PORTS write ports,
 * x0 hard-wired to zero
 */
`timescale 1ns/1ns

module int_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                         clk_i,
    input  logic                                         rst_uarch_ni,
    input  issue_pkg::reg_addr_t                         raddr_a_i,
    input  issue_pkg::reg_addr_t                         raddr_b_i,
    output issue_pkg::xlen_t                             rdata_a_o,
    output issue_pkg::xlen_t                             rdata_b_o,
    input  issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
    input  issue_pkg::xlen_t     [NR_COMMIT_PORTS-1:0]   wdata_i,
    input  logic                 [NR_COMMIT_PORTS-1:0]   we_i
);
    import issue_pkg::*;

    // x1 .. x31, x0 has no storage
    xlen_t regs_q [NUM_REGS-1:1];

    // --------------------
    // write ports
    // --------------------
    // ports are walked in ascending order, so the last matching
    // (highest-numbered) port decides the value
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // --------------------
    // read ports
    // --------------------
    // no write-through, a value written at an edge shows up after it
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // zero register on both ports, also right after a commit aimed at x0
    a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
        ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and
        ((raddr_b_i == '0) |-> (rdata_b_o == '0)))
        else $error("x0 read back a nonzero value");

endmodule

// File: hdl/issue_pkg.sv
/*
 * shared types of the operand-read issue stage
 * width typedefs, functional unit and operation enums,
 * the scoreboard issue entry, the execute-unit data word
 * and the per-register clobber table
 */
package issue_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned NUM_REGS = 32;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  trans_id_t;

    // --------------------
    // encodings
    // --------------------
    // NONE must stay at zero, reset values rely on it
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_t;

    // ADD at zero doubles as the idle operation
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        MUL,
        LW,
        SW,
        BEQ,
        JAL,
        CSRRW,
        SFENCE_VMA
    } fu_op_t;

    // --------------------
    // bundles
    // --------------------
    // one entry as handed over by the scoreboard
    typedef struct packed {
        addr_t     pc;
        trans_id_t trans_id;
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     result;     // immediate
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        logic      ex_valid;   // exception already raised upstream
    } issue_entry_t;

    // operands and control for the execute units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // unit that will write each register, NONE if no write pending
    typedef fu_t [NUM_REGS-1:0] clobber_table_t;

endpackage
